// ==== hw/trace_consts.svh ====
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

// Datapath widths
`define TRACE_XLEN          32      // Data, PC and instruction width
`define TRACE_REG_AWIDTH    5       // Integer register index
`define TRACE_EC_WIDTH      4       // mcause exception code

// Entry queue between capture and sequencer
`define TRACE_FIFO_DEPTH    4

// mstatus bit positions
`define MSTATUS_MIE_OFF     3
`define MSTATUS_MPIE_OFF    7
`define MSTATUS_MPP_OFF     11      // Two bits wide
`define MSTATUS_MPP_VAL     2'b11   // Machine mode only

// mie and mip share these positions
`define MIE_MSIE_OFF        3
`define MIE_MTIE_OFF        7
`define MIE_MEIE_OFF        11

`endif // TRACE_CONSTS_SVH

// ==== hw/trace_csr_pkg.sv ====
`default_nettype none

`include "trace_consts.svh"

package trace_csr_pkg;

    // Raw CSR fields as delivered by the core
    typedef struct packed {
        logic                           mstatus_mie;
        logic                           mstatus_mpie;
        logic                           mie_meie;
        logic                           mie_mtie;
        logic                           mie_msie;
        logic                           mip_meip;
        logic                           mip_mtip;
        logic                           mip_msip;
        logic [`TRACE_XLEN-1:1]         mepc;           // Bit 0 is always zero with RVC
        logic                           mcause_irq;
        logic [`TRACE_EC_WIDTH-1:0]     mcause_ec;
        logic [`TRACE_XLEN-1:0]         mtval;
    } csr_state_s;

    // Architectural 32-bit register images, as a debugger would read them
    typedef struct packed {
        logic [`TRACE_XLEN-1:0]         mstatus;
        logic [`TRACE_XLEN-1:0]         mie;
        logic [`TRACE_XLEN-1:0]         mip;
        logic [`TRACE_XLEN-1:0]         mepc;
        logic [`TRACE_XLEN-1:0]         mcause;
        logic [`TRACE_XLEN-1:0]         mtval;
    } csr_view_s;

endpackage : trace_csr_pkg

`default_nettype wire

// ==== hw/trace_pkg.sv ====
`default_nettype none

`include "trace_consts.svh"

package trace_pkg;

    // Commit event class, higher value wins
    typedef enum logic [1:0] {
        EV_NONE = 2'd0,
        EV_WAKE = 2'd1,
        EV_IRQ  = 2'd2,
        EV_EXC  = 2'd3
    } event_e;

    // Record field id; 0..31 is an integer register index
    typedef enum logic [5:0] {
        FLD_NONE    = 6'd32,    // No register reported
        FLD_MSTATUS = 6'd33,
        FLD_MEPC    = 6'd34,
        FLD_MCAUSE  = 6'd35,
        FLD_MTVAL   = 6'd36,
        FLD_MIP     = 6'd37,
        FLD_MIE     = 6'd38
    } field_e;

    // Retire information from the pipeline
    typedef struct packed {
        logic                           pc_en;      // PC update strobe
        logic [`TRACE_XLEN-1:0]         npc;
        logic [`TRACE_XLEN-1:0]         instr;
        logic                           wb_en;      // Register file write
        logic [`TRACE_REG_AWIDTH-1:0]   wb_addr;
        logic [`TRACE_XLEN-1:0]         wb_data;
    } commit_s;

    typedef struct packed {
        logic                           exc;
        logic                           irq;
        logic                           wake;
    } events_s;

    // One queued commit
    typedef struct packed {
        event_e                         ev;
        logic [`TRACE_XLEN-1:0]         pc;
        logic [`TRACE_XLEN-1:0]         npc;
        logic [`TRACE_XLEN-1:0]         instr;
        logic                           wb_valid;   // Write to a nonzero register
        logic [`TRACE_REG_AWIDTH-1:0]   wb_addr;
        logic [`TRACE_XLEN-1:0]         wb_data;
        trace_csr_pkg::csr_view_s       csr;
    } entry_s;

    // Output record, one per clock
    typedef struct packed {
        event_e                         ev;
        logic [`TRACE_XLEN-1:0]         pc;
        logic [`TRACE_XLEN-1:0]         instr;
        logic [`TRACE_XLEN-1:0]         npc;
        field_e                         fld;
        logic [`TRACE_XLEN-1:0]         value;
        logic                           last;       // Final record of the entry
    } record_s;

endpackage : trace_pkg

`default_nettype wire

// ==== hw/trace_capture.sv ====
`default_nettype none

`include "trace_consts.svh"

module trace_capture (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire trace_pkg::commit_s         commit_i,
    input  wire trace_pkg::events_s         events_i,
    input  wire trace_csr_pkg::csr_state_s  csr_i,
    output logic                            ent_valid_o,    // One cycle per commit
    output trace_pkg::entry_s               ent_o
);

    logic                           strobe;     // Commit this cycle
    logic [`TRACE_XLEN-1:0]         npc_q;      // Last reported next-PC
    trace_pkg::event_e              ev;
    trace_csr_pkg::csr_view_s       view;
    trace_pkg::entry_s              ent_d;

    assign strobe = commit_i.pc_en | commit_i.wb_en;

    // Exception over interrupt over wake-up
    always_comb begin
        if (events_i.exc) begin
            ev = trace_pkg::EV_EXC;
        end else if (events_i.irq) begin
            ev = trace_pkg::EV_IRQ;
        end else if (events_i.wake) begin
            ev = trace_pkg::EV_WAKE;
        end else begin
            ev = trace_pkg::EV_NONE;
        end
    end

    // ------------------------------------------------------------------------
    // CSR register images
    // ------------------------------------------------------------------------
    always_comb begin
        view = '0;                                                  // Unimplemented bits read 0
        view.mstatus[`MSTATUS_MIE_OFF]                      = csr_i.mstatus_mie;
        view.mstatus[`MSTATUS_MPIE_OFF]                     = csr_i.mstatus_mpie;
        view.mstatus[`MSTATUS_MPP_OFF+1:`MSTATUS_MPP_OFF]   = `MSTATUS_MPP_VAL;
        view.mie[`MIE_MSIE_OFF] = csr_i.mie_msie;
        view.mie[`MIE_MTIE_OFF] = csr_i.mie_mtie;
        view.mie[`MIE_MEIE_OFF] = csr_i.mie_meie;
        view.mip[`MIE_MSIE_OFF] = csr_i.mip_msip;                   // mip pending bits line up with mie
        view.mip[`MIE_MTIE_OFF] = csr_i.mip_mtip;
        view.mip[`MIE_MEIE_OFF] = csr_i.mip_meip;
        view.mepc   = {csr_i.mepc, 1'b0};                           // Halfword aligned
        view.mcause = {csr_i.mcause_irq,
                       {(`TRACE_XLEN-1-`TRACE_EC_WIDTH){1'b0}},
                       csr_i.mcause_ec};                            // Interrupt flag in bit 31
        view.mtval  = csr_i.mtval;
    end

    // Entry as seen at the commit
    always_comb begin
        ent_d.ev       = ev;
        ent_d.pc       = npc_q;                                     // Current PC is the previous next-PC
        ent_d.npc      = commit_i.npc;
        ent_d.instr    = commit_i.instr;
        ent_d.wb_valid = commit_i.wb_en & (commit_i.wb_addr != '0); // x0 writes are not reported
        ent_d.wb_addr  = commit_i.wb_addr;
        ent_d.wb_data  = commit_i.wb_data;
        ent_d.csr      = view;
    end

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ent_valid_o <= 1'b0;
            npc_q       <= '0;                                      // PC chain starts at 0
        end else begin
            ent_valid_o <= strobe;
            if (strobe) begin
                npc_q <= commit_i.npc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            ent_o <= ent_d;
        end
    end

endmodule : trace_capture

`default_nettype wire

// ==== hw/trace_fifo.sv ====
`default_nettype none

module trace_fifo #(
    parameter int DEPTH = 4
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               wr_i,
    input  wire trace_pkg::entry_s  wr_ent_i,
    input  wire logic               pop_i,
    output logic                    valid_o,        // Head holds an entry
    output trace_pkg::entry_s       ent_o,          // Head entry
    output logic                    overflow_o      // Sticky, entry lost
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    trace_pkg::entry_s  mem [DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [CW-1:0]      count;
    logic               full;
    logic               push;
    logic               pull;

    // Pointer step with wrap at DEPTH-1
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (count == CW'(DEPTH));
    assign push    = wr_i & ~full;                  // Dropped when full
    assign pull    = pop_i & valid_o;
    assign valid_o = (count != '0);
    assign ent_o   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pull) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (push && !pull) begin
                count <= count + 1'b1;
            end else if (!push && pull) begin
                count <= count - 1'b1;
            end
            if (wr_i && full) begin
                overflow_o <= 1'b1;                 // Held until reset
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_ent_i;
        end
    end

endmodule : trace_fifo

`default_nettype wire

// ==== hw/trace_record_seq.sv ====
`default_nettype none

module trace_record_seq (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               valid_i,        // FIFO head valid
    input  wire trace_pkg::entry_s  ent_i,
    output logic                    pop_o,
    output logic                    rec_valid_o,
    output trace_pkg::record_s      rec_o
);

    logic                   busy_q;         // Records of ent_q in flight
    logic [1:0]             idx_q;          // Record index within the entry
    logic [1:0]             last_idx;
    logic                   last;
    logic                   wake_hit;       // Enabled interrupt pending
    trace_pkg::entry_s      ent_q;
    trace_pkg::field_e      fld;
    logic [31:0]            value;

    assign wake_hit = |(ent_q.csr.mip & ent_q.csr.mie);

    // Records per entry, minus one
    always_comb begin
        case (ent_q.ev)
            trace_pkg::EV_WAKE: last_idx = wake_hit ? 2'd1 : 2'd0;
            trace_pkg::EV_IRQ,
            trace_pkg::EV_EXC:  last_idx = 2'd3;
            default:            last_idx = 2'd0;
        endcase
    end

    assign last  = (idx_q == last_idx);
    assign pop_o = valid_i & (~busy_q | last);      // Next entry follows without a gap

    // ------------------------------------------------------------------------
    // Field select
    // ------------------------------------------------------------------------
    always_comb begin
        fld   = trace_pkg::FLD_NONE;
        value = '0;
        case (ent_q.ev)
            trace_pkg::EV_NONE: begin
                if (ent_q.wb_valid) begin
                    fld   = trace_pkg::field_e'({1'b0, ent_q.wb_addr});
                    value = ent_q.wb_data;
                end
            end
            trace_pkg::EV_WAKE: begin
                if (wake_hit) begin                 // mip first, then mie
                    fld   = (idx_q == 2'd0) ? trace_pkg::FLD_MIP : trace_pkg::FLD_MIE;
                    value = (idx_q == 2'd0) ? ent_q.csr.mip : ent_q.csr.mie;
                end
            end
            default: begin                          // Trap entry block
                case (idx_q)
                    2'd0: begin
                        fld   = trace_pkg::FLD_MSTATUS;
                        value = ent_q.csr.mstatus;
                    end
                    2'd1: begin
                        fld   = trace_pkg::FLD_MEPC;
                        value = ent_q.csr.mepc;
                    end
                    2'd2: begin
                        fld   = trace_pkg::FLD_MCAUSE;
                        value = ent_q.csr.mcause;
                    end
                    default: begin
                        fld   = trace_pkg::FLD_MTVAL;
                        value = ent_q.csr.mtval;
                    end
                endcase
            end
        endcase
    end

    assign rec_valid_o = busy_q;
    assign rec_o       = '{ev: ent_q.ev, pc: ent_q.pc, instr: ent_q.instr, npc: ent_q.npc,
                           fld: fld, value: value, last: last};

    // Walk control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (pop_o) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (busy_q) begin
            if (last) begin
                busy_q <= 1'b0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            ent_q <= ent_i;                         // Head latched on pop
        end
    end

endmodule : trace_record_seq

`default_nettype wire

// ==== hw/trace_top.sv ====
`default_nettype none

`include "trace_consts.svh"

module trace_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire trace_pkg::commit_s         commit_i,
    input  wire trace_pkg::events_s         events_i,
    input  wire trace_csr_pkg::csr_state_s  csr_i,
    output logic                            rec_valid_o,
    output trace_pkg::record_s              rec_o,
    output logic                            overflow_o
);

    // ------------------------------------------------------------------------
    // Capture -> FIFO -> sequencer
    // ------------------------------------------------------------------------
    logic                   ent_valid;      // Captured commit strobe
    trace_pkg::entry_s      ent;
    logic                   fifo_valid;
    trace_pkg::entry_s      fifo_ent;       // Queue head
    logic                   pop;

    trace_capture u_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .commit_i    (commit_i),
        .events_i    (events_i),
        .csr_i       (csr_i),
        .ent_valid_o (ent_valid),
        .ent_o       (ent)
    );

    trace_fifo #(
        .DEPTH (`TRACE_FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_i       (ent_valid),
        .wr_ent_i   (ent),
        .pop_i      (pop),
        .valid_o    (fifo_valid),
        .ent_o      (fifo_ent),
        .overflow_o (overflow_o)
    );

    trace_record_seq u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (fifo_valid),
        .ent_i       (fifo_ent),
        .pop_o       (pop),
        .rec_valid_o (rec_valid_o),
        .rec_o       (rec_o)
    );

endmodule : trace_top

`default_nettype wire

// ==== dv/tb_trace_checker.sv ====
`default_nettype none

module tb_trace_checker (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       rec_valid_i,
    input  wire trace_pkg::record_s         rec_i,
    input  wire logic                       overflow_i,
    input  wire logic                       burst_i,        // Overflow allowed from here on
    input  wire logic                       exp_push_i,
    input  wire trace_pkg::record_s [3:0]   exp_recs_i,
    input  wire logic [2:0]                 exp_cnt_i,
    input  wire logic                       exp_drop_i,
    input  wire logic                       done_i,
    output logic                            finished_o,
    output int                              value_errs_o,
    output int                              other_errs_o
);

    trace_pkg::record_s exp_q [$];
    bit                 drop_q [$];     // Per record, may be lost in the burst
    bit                 in_group;       // Mid-way through a received group
    bit                 ovf_seen;

    task automatic push_one(input trace_pkg::record_s r);
        exp_q.push_back(r);
        drop_q.push_back(exp_drop_i);
    endtask

    // Remove one whole group from the head
    task automatic skip_group();
        trace_pkg::record_s r;
        r = exp_q.pop_front();
        void'(drop_q.pop_front());
        while (!r.last && exp_q.size() > 0) begin
            r = exp_q.pop_front();
            void'(drop_q.pop_front());
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            value_errs_o = value_errs_o + 1;
        end
    endtask

    // ------------------------------------------------------------------------
    // Record compare
    // ------------------------------------------------------------------------
    task automatic compare_record(input trace_pkg::record_s got);
        trace_pkg::record_s exp;
        if (!in_group) begin                        // Groups lost to overflow match no npc
            while (exp_q.size() > 0 && drop_q[0] && exp_q[0].npc != got.npc) begin
                skip_group();
            end
        end
        if (exp_q.size() == 0) begin
            $display("Record with npc %h arrived while none was expected", got.npc);
            other_errs_o = other_errs_o + 1;
        end else begin
            exp = exp_q.pop_front();
            void'(drop_q.pop_front());
            check_field("rec_o.ev", 32'(exp.ev), 32'(got.ev));
            check_field("rec_o.pc", exp.pc, got.pc);
            check_field("rec_o.instr", exp.instr, got.instr);
            check_field("rec_o.npc", exp.npc, got.npc);
            check_field("rec_o.fld", 32'(exp.fld), 32'(got.fld));
            check_field("rec_o.value", exp.value, got.value);
            check_field("rec_o.last", 32'(exp.last), 32'(got.last));
        end
        in_group = !got.last;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            in_group     = 1'b0;
            ovf_seen     = 1'b0;
            finished_o   = 1'b0;
            value_errs_o = 0;
            other_errs_o = 0;
        end else begin
            if ($isunknown({rec_valid_i, overflow_i})) begin
                $display("Record valid or overflow flag is unknown after reset");
                other_errs_o = other_errs_o + 1;
            end
            if (exp_push_i) begin
                push_one(exp_recs_i[0]);
                if (exp_cnt_i > 3'd1) push_one(exp_recs_i[1]);
                if (exp_cnt_i > 3'd2) push_one(exp_recs_i[2]);
                if (exp_cnt_i > 3'd3) push_one(exp_recs_i[3]);
            end
            if (rec_valid_i) begin
                compare_record(rec_i);
            end
            if (overflow_i && !burst_i && !ovf_seen) begin
                $display("Overflow flag set while commits were spaced");
                other_errs_o = other_errs_o + 1;
                ovf_seen     = 1'b1;                // Reported once
            end
            if (done_i && !finished_o) begin
                while (exp_q.size() > 0 && drop_q[0]) begin
                    skip_group();
                end
                if (exp_q.size() > 0) begin
                    $display("%0d expected records never arrived", exp_q.size());
                    other_errs_o = other_errs_o + 1;
                end
                if (in_group) begin
                    $display("Last record group ended without its final record");
                    other_errs_o = other_errs_o + 1;
                end
                if (!overflow_i) begin
                    $display("Overflow flag was not set by the burst");
                    other_errs_o = other_errs_o + 1;
                end
                finished_o = 1'b1;
            end
        end
    end

endmodule : tb_trace_checker

`default_nettype wire

// ==== dv/tb_trace_top.sv ====
`default_nettype none

`include "trace_consts.svh"

module tb_trace_top;

    localparam int          N_SPACED       = 120;      // Commits at four or more cycles apart
    localparam int          N_BURST        = 16;       // Back-to-back exceptions at the end
    localparam int          TIMEOUT_CYCLES = (N_SPACED + N_BURST) * 8 + 200;
    localparam logic [31:0] LFSR_SEED      = 32'd8032;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1

    logic                       clk;
    logic                       rst_n;
    trace_pkg::commit_s         commit;
    trace_pkg::events_s         events;
    trace_csr_pkg::csr_state_s  csr;
    logic                       rec_valid;
    trace_pkg::record_s         rec;
    logic                       overflow;

    // Expected records handed to the checker, one commit per strobe
    logic                       exp_push;
    trace_pkg::record_s [3:0]   exp_recs;
    logic [2:0]                 exp_cnt;
    logic                       exp_drop;       // Group may be lost to overflow
    logic                       burst;
    logic                       done;
    logic                       finished;
    int                         value_errs;
    int                         other_errs;

    logic [31:0]                lfsr;
    logic [31:0]                model_npc;      // Reference PC chain
    int                         cycles;

    trace_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .commit_i    (commit),
        .events_i    (events),
        .csr_i       (csr),
        .rec_valid_o (rec_valid),
        .rec_o       (rec),
        .overflow_o  (overflow)
    );

    tb_trace_checker u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .rec_valid_i  (rec_valid),
        .rec_i        (rec),
        .overflow_i   (overflow),
        .burst_i      (burst),
        .exp_push_i   (exp_push),
        .exp_recs_i   (exp_recs),
        .exp_cnt_i    (exp_cnt),
        .exp_drop_i   (exp_drop),
        .done_i       (done),
        .finished_o   (finished),
        .value_errs_o (value_errs),
        .other_errs_o (other_errs)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic trace_pkg::record_s make_rec(input trace_pkg::record_s base,
            input trace_pkg::field_e fld, input logic [31:0] value, input logic last);
        trace_pkg::record_s r;
        r       = base;
        r.fld   = fld;
        r.value = value;
        r.last  = last;
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    task automatic predict(input trace_pkg::commit_s c, input trace_pkg::events_s e,
                           input trace_csr_pkg::csr_state_s s, input logic drop);
        trace_pkg::record_s base;
        logic [31:0]        mstatus;
        logic [31:0]        mie_w;
        logic [31:0]        mip_w;
        logic [31:0]        mcause;
        if (e.exc) begin
            base.ev = trace_pkg::EV_EXC;
        end else if (e.irq) begin
            base.ev = trace_pkg::EV_IRQ;
        end else if (e.wake) begin
            base.ev = trace_pkg::EV_WAKE;
        end else begin
            base.ev = trace_pkg::EV_NONE;
        end
        base.pc    = model_npc;                    // Previous next-PC, 0 after reset
        base.instr = c.instr;
        base.npc   = c.npc;
        base.fld   = trace_pkg::FLD_NONE;
        base.value = '0;
        base.last  = 1'b0;
        model_npc  = c.npc;
        mstatus = (32'(s.mstatus_mie) << `MSTATUS_MIE_OFF)
                | (32'(s.mstatus_mpie) << `MSTATUS_MPIE_OFF)
                | (32'(`MSTATUS_MPP_VAL) << `MSTATUS_MPP_OFF);
        mie_w = (32'(s.mie_msie) << `MIE_MSIE_OFF) | (32'(s.mie_mtie) << `MIE_MTIE_OFF)
              | (32'(s.mie_meie) << `MIE_MEIE_OFF);
        mip_w = (32'(s.mip_msip) << `MIE_MSIE_OFF) | (32'(s.mip_mtip) << `MIE_MTIE_OFF)
              | (32'(s.mip_meip) << `MIE_MEIE_OFF);
        mcause = {s.mcause_irq, 27'd0, s.mcause_ec};   // Interrupt flag on top
        exp_recs = '0;
        case (base.ev)
            trace_pkg::EV_NONE: begin
                exp_cnt = 3'd1;
                if (c.wb_en && c.wb_addr != '0) begin
                    exp_recs[0] = make_rec(base, trace_pkg::field_e'({1'b0, c.wb_addr}),
                                           c.wb_data, 1'b1);
                end else begin
                    exp_recs[0] = make_rec(base, trace_pkg::FLD_NONE, '0, 1'b1);
                end
            end
            trace_pkg::EV_WAKE: begin
                if ((mip_w & mie_w) != '0) begin
                    exp_cnt     = 3'd2;
                    exp_recs[0] = make_rec(base, trace_pkg::FLD_MIP, mip_w, 1'b0);
                    exp_recs[1] = make_rec(base, trace_pkg::FLD_MIE, mie_w, 1'b1);
                end else begin
                    exp_cnt     = 3'd1;
                    exp_recs[0] = make_rec(base, trace_pkg::FLD_NONE, '0, 1'b1);
                end
            end
            default: begin                         // Trap block, same for exc and irq
                exp_cnt     = 3'd4;
                exp_recs[0] = make_rec(base, trace_pkg::FLD_MSTATUS, mstatus, 1'b0);
                exp_recs[1] = make_rec(base, trace_pkg::FLD_MEPC, {s.mepc, 1'b0}, 1'b0);
                exp_recs[2] = make_rec(base, trace_pkg::FLD_MCAUSE, mcause, 1'b0);
                exp_recs[3] = make_rec(base, trace_pkg::FLD_MTVAL, s.mtval, 1'b1);
            end
        endcase
        exp_drop = drop;
        exp_push = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic drive_commit(input int idx, input logic in_burst);
        trace_pkg::commit_s         c;
        trace_pkg::events_s         e;
        trace_csr_pkg::csr_state_s  s;
        c.pc_en   = 1'(rand_bits(1));
        c.wb_en   = 1'(rand_bits(1));
        if (!c.pc_en && !c.wb_en) begin
            c.pc_en = 1'b1;                         // Every call is a commit
        end
        c.npc     = {20'(rand_bits(20)), 12'(idx)};    // Unique per commit
        c.instr   = rand_bits(32);
        c.wb_addr = (rand_bits(3) == 0) ? 5'd0 : 5'(rand_bits(5));  // x0 now and then
        c.wb_data = rand_bits(32);
        e.exc     = in_burst | (rand_bits(2) == 0);
        e.irq     = (rand_bits(2) == 0);
        e.wake    = (rand_bits(2) == 0);
        s.mstatus_mie  = 1'(rand_bits(1));
        s.mstatus_mpie = 1'(rand_bits(1));
        s.mie_meie     = 1'(rand_bits(1));
        s.mie_mtie     = 1'(rand_bits(1));
        s.mie_msie     = 1'(rand_bits(1));
        s.mip_meip     = 1'(rand_bits(1));
        s.mip_mtip     = 1'(rand_bits(1));
        s.mip_msip     = 1'(rand_bits(1));
        s.mepc         = 31'(rand_bits(31));
        s.mcause_irq   = 1'(rand_bits(1));
        s.mcause_ec    = 4'(rand_bits(4));
        s.mtval        = rand_bits(32);
        predict(c, e, s, in_burst);
        commit = c;
        events = e;
        csr    = s;
    endtask

    task automatic set_idle();
        commit.pc_en = 1'b0;
        commit.wb_en = 1'b0;
        exp_push     = 1'b0;
    endtask

    initial begin
        rst_n     = 1'b0;
        commit    = '0;
        events    = '0;
        csr       = '0;
        exp_push  = 1'b0;
        exp_recs  = '0;
        exp_cnt   = '0;
        exp_drop  = 1'b0;
        burst     = 1'b0;
        done      = 1'b0;
        lfsr      = LFSR_SEED;
        model_npc = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < N_SPACED; i++) begin
            drive_commit(i, 1'b0);
            @(negedge clk);
            set_idle();
            repeat (3 + rand_bits(2)) @(negedge clk);  // Period of 4 to 7 cycles
        end
        burst = 1'b1;
        for (int i = 0; i < N_BURST; i++) begin
            drive_commit(N_SPACED + i, 1'b1);
            @(negedge clk);
        end
        set_idle();
        repeat (4) @(negedge clk);                  // Last commit reaches the FIFO
        while (rec_valid) begin
            @(negedge clk);
        end
        done = 1'b1;
        while (!finished) begin
            @(negedge clk);
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Cycle limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("Run did not finish within %0d cycles, records still outstanding",
                 TIMEOUT_CYCLES);
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs + 1);
        $display("Testbench failed");
        $finish;
    end

endmodule : tb_trace_top

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/trace_csr_pkg.sv
hw/trace_pkg.sv
hw/trace_capture.sv
hw/trace_fifo.sv
hw/trace_record_seq.sv
hw/trace_top.sv
dv/tb_trace_checker.sv
dv/tb_trace_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the trace record generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_trace_top -Mdir obj_dir

out="$(./obj_dir/Vtb_trace_top)"
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
else
    exit 1
fi
